/* Bender.yml */
package:
  name: sap_cpu

sources:
  - include_dirs:
      - include
    files:
      - logic/arch_defs_pkg.sv
      - logic/alu.sv
      - logic/control_unit.sv
      - logic/cpu.sv
      - logic/memory_io.sv
      - logic/sap_top.sv
  - target: test
    files:
      - tests/sap_chk.sv
      - tests/sap_tb.sv

/* include/sap_defs.svh */
`ifndef SAP_DEFS_SVH
`define SAP_DEFS_SVH

// ======================================================================
// Datapath widths
// ======================================================================

// Width of A, B, IR, the bus and every RAM word
`define SAP_DATA_WIDTH    8

// PC and MAR width, enough to reach every RAM word
`define SAP_ADDR_WIDTH    4

// Instruction layout is opcode in the high nibble, operand in the low one
`define SAP_OPCODE_WIDTH  4
`define SAP_OPERAND_WIDTH 4

// ======================================================================
// Status and storage
// ======================================================================

// Negative, carry and zero
`define SAP_FLAG_COUNT    3

// Unified program and data RAM
`define SAP_RAM_DEPTH     16

`endif

/* logic/alu.sv */
`timescale 1ns/100ps
`include "sap_defs.svh"

module alu (
    input  logic                   clk,
    input  logic                   rst_i,
    input  arch_defs_pkg::data_t   a_i,
    input  arch_defs_pkg::data_t   b_i,
    input  arch_defs_pkg::alu_op_t alu_op_i,
    output arch_defs_pkg::data_t   result_o,
    output arch_defs_pkg::flags_t  flags_o
);

    // One extra bit catches the carry out or the borrow
    logic [`SAP_DATA_WIDTH:0] wide_d;
    arch_defs_pkg::data_t     result_q;
    arch_defs_pkg::flags_t    flags_q;

    // Unsigned add or subtract on zero-extended operands
    always_comb begin
        if (alu_op_i == arch_defs_pkg::ALU_SUB) begin
            wide_d = {1'b0, a_i} - {1'b0, b_i};
        end else begin
            wide_d = {1'b0, a_i} + {1'b0, b_i};
        end
    end

    // Result and flags latch every cycle
    // Microcode picks them up one step after selecting the operation
    always_ff @(posedge clk) begin
        if (rst_i) begin
            result_q <= '0;
            flags_q  <= '0;
        end else begin
            result_q         <= wide_d[`SAP_DATA_WIDTH-1:0];
            flags_q.zero     <= (wide_d[`SAP_DATA_WIDTH-1:0] == '0);
            flags_q.negative <= wide_d[`SAP_DATA_WIDTH-1];
            // For SUB a set top bit is a borrow, so carry means A >= B
            if (alu_op_i == arch_defs_pkg::ALU_SUB) begin
                flags_q.carry <= ~wide_d[`SAP_DATA_WIDTH];
            end else begin
                flags_q.carry <= wide_d[`SAP_DATA_WIDTH];
            end
        end
    end

    assign result_o = result_q;
    assign flags_o  = flags_q;

endmodule

/* logic/arch_defs_pkg.sv */
`include "sap_defs.svh"

package arch_defs_pkg;

    // ==================================================================
    // Width types
    // ==================================================================
    typedef logic [`SAP_DATA_WIDTH-1:0]    data_t;
    typedef logic [`SAP_ADDR_WIDTH-1:0]    addr_t;
    typedef logic [`SAP_OPCODE_WIDTH-1:0]  opcode_t;
    typedef logic [`SAP_OPERAND_WIDTH-1:0] operand_t;
    typedef logic [1:0]                    alu_op_t;

    // ==================================================================
    // Instruction set
    // ==================================================================
    localparam opcode_t NOP = opcode_t'(0);
    localparam opcode_t LDA = opcode_t'(1);
    localparam opcode_t LDB = opcode_t'(2);
    localparam opcode_t LDI = opcode_t'(3);
    localparam opcode_t ADD = opcode_t'(4);
    localparam opcode_t SUB = opcode_t'(5);
    localparam opcode_t STA = opcode_t'(6);
    localparam opcode_t OUT = opcode_t'(7);
    localparam opcode_t JMP = opcode_t'(8);
    localparam opcode_t JZ  = opcode_t'(9);
    localparam opcode_t JC  = opcode_t'(10);
    localparam opcode_t JN  = opcode_t'(11);
    localparam opcode_t HLT = opcode_t'(12);

    // ALU operation select
    localparam alu_op_t ALU_ADD = 2'd0;
    localparam alu_op_t ALU_SUB = 2'd1;

    // Microstep counter, T0 and T1 are always the fetch
    typedef enum logic [2:0] {T0, T1, T2, T3, T4} microstep_t;

    // Bit 0 is zero, bit 2 is negative
    typedef struct packed {
        logic negative;
        logic carry;
        logic zero;
    } flags_t;

    // One microinstruction
    typedef struct packed {
        // Register load enables
        logic    load_a;
        logic    load_b;
        logic    load_ir;
        logic    load_pc;
        logic    load_mar;
        logic    load_ram;
        logic    load_o;
        logic    load_flags;
        logic    load_sets_zn;
        // Bus drivers, listed in priority order
        logic    oe_pc;
        logic    oe_ram;
        logic    oe_ir;
        logic    oe_alu;
        logic    oe_a;
        // Miscellaneous
        alu_op_t alu_op;
        logic    pc_enable;
        logic    halt;
    } control_word_t;

endpackage

/* logic/control_unit.sv */
`timescale 1ns/100ps

module control_unit (
    input  logic                         clk,
    input  logic                         rst_i,
    input  arch_defs_pkg::opcode_t       opcode_i,
    input  arch_defs_pkg::flags_t        flags_i,
    output arch_defs_pkg::control_word_t control_word_o
);

    arch_defs_pkg::microstep_t    step_q;
    arch_defs_pkg::microstep_t    step_next;
    arch_defs_pkg::microstep_t    step_inc;
    arch_defs_pkg::control_word_t cw;

    // Plain successor of the current step
    always_comb begin
        case (step_q)
            arch_defs_pkg::T0: step_inc = arch_defs_pkg::T1;
            arch_defs_pkg::T1: step_inc = arch_defs_pkg::T2;
            arch_defs_pkg::T2: step_inc = arch_defs_pkg::T3;
            arch_defs_pkg::T3: step_inc = arch_defs_pkg::T4;
            default:           step_inc = arch_defs_pkg::T0;
        endcase
    end

    // ==================================================================
    // Microcode ROM
    // ==================================================================
    always_comb begin
        cw        = '0;
        step_next = step_inc;
        if (step_q == arch_defs_pkg::T0) begin
            // Fetch address phase
            cw.oe_pc    = 1'b1;
            cw.load_mar = 1'b1;
        end else if (step_q == arch_defs_pkg::T1) begin
            // Fetch data phase, IR valid from the next cycle
            cw.oe_ram    = 1'b1;
            cw.load_ir   = 1'b1;
            cw.pc_enable = 1'b1;
        end else begin
            // Single-step opcodes finish here unless changed below
            step_next = arch_defs_pkg::T0;
            case (opcode_i)
                arch_defs_pkg::NOP: begin
                    // No execute step
                    // This slot already does the next fetch's address phase
                    cw.oe_pc    = 1'b1;
                    cw.load_mar = 1'b1;
                    step_next   = arch_defs_pkg::T1;
                end
                arch_defs_pkg::LDA,
                arch_defs_pkg::LDB,
                arch_defs_pkg::STA: begin
                    if (step_q == arch_defs_pkg::T2) begin
                        // Operand is the RAM address
                        cw.oe_ir    = 1'b1;
                        cw.load_mar = 1'b1;
                        step_next   = step_inc;
                    end else if (opcode_i == arch_defs_pkg::STA) begin
                        cw.load_ram = 1'b1;
                    end else begin
                        cw.oe_ram       = 1'b1;
                        cw.load_a       = (opcode_i == arch_defs_pkg::LDA);
                        cw.load_b       = (opcode_i == arch_defs_pkg::LDB);
                        cw.load_flags   = 1'b1;
                        cw.load_sets_zn = 1'b1;
                    end
                end
                arch_defs_pkg::LDI: begin
                    cw.oe_ir        = 1'b1;
                    cw.load_a       = 1'b1;
                    cw.load_flags   = 1'b1;
                    cw.load_sets_zn = 1'b1;
                end
                arch_defs_pkg::ADD,
                arch_defs_pkg::SUB: begin
                    // Same operation on both steps keeps the ALU output steady
                    if (opcode_i == arch_defs_pkg::SUB) begin
                        cw.alu_op = arch_defs_pkg::ALU_SUB;
                    end else begin
                        cw.alu_op = arch_defs_pkg::ALU_ADD;
                    end
                    if (step_q == arch_defs_pkg::T2) begin
                        // ALU latches A and B at the end of this step
                        step_next = step_inc;
                    end else begin
                        cw.oe_alu     = 1'b1;
                        cw.load_a     = 1'b1;
                        cw.load_flags = 1'b1;
                    end
                end
                arch_defs_pkg::OUT: begin
                    cw.oe_a   = 1'b1;
                    cw.load_o = 1'b1;
                end
                arch_defs_pkg::JMP: begin
                    cw.oe_ir   = 1'b1;
                    cw.load_pc = 1'b1;
                end
                arch_defs_pkg::JZ,
                arch_defs_pkg::JC,
                arch_defs_pkg::JN: begin
                    // Not taken just falls through to the next fetch
                    cw.oe_ir   = 1'b1;
                    cw.load_pc = ((opcode_i == arch_defs_pkg::JZ) && flags_i.zero)
                              || ((opcode_i == arch_defs_pkg::JC) && flags_i.carry)
                              || ((opcode_i == arch_defs_pkg::JN) && flags_i.negative);
                end
                arch_defs_pkg::HLT: begin
                    // Sequencer parks here until reset
                    cw.halt   = 1'b1;
                    step_next = step_q;
                end
                default: begin
                    // Unused opcodes do nothing for one step
                    cw = '0;
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (rst_i) begin
            step_q <= arch_defs_pkg::T0;
        end else begin
            step_q <= step_next;
        end
    end

    assign control_word_o = cw;

endmodule

/* logic/cpu.sv */
`timescale 1ns/100ps
`include "sap_defs.svh"

module cpu (
    input  logic                  clk,
    input  logic                  rst_i,
    input  arch_defs_pkg::data_t  mem_rdata_i,
    output arch_defs_pkg::addr_t  mem_addr_o,
    output logic                  mem_read_o,
    output logic                  mem_write_o,
    output arch_defs_pkg::data_t  mem_wdata_o,
    output logic                  load_o,
    output logic                  halt_o,
    output arch_defs_pkg::flags_t flags_o
);

    arch_defs_pkg::control_word_t cw;
    arch_defs_pkg::data_t         bus;
    arch_defs_pkg::addr_t         pc_q;
    arch_defs_pkg::addr_t         mar_q;
    arch_defs_pkg::data_t         a_q;
    arch_defs_pkg::data_t         b_q;
    arch_defs_pkg::data_t         ir_q;
    arch_defs_pkg::opcode_t       opcode;
    arch_defs_pkg::operand_t      operand;
    arch_defs_pkg::data_t         alu_result;
    arch_defs_pkg::flags_t        alu_flags;
    arch_defs_pkg::flags_t        flags_d;
    logic [`SAP_FLAG_COUNT-1:0]   flags_q;

    // IR split into its two nibbles
    assign opcode  = ir_q[`SAP_DATA_WIDTH-1 -: `SAP_OPCODE_WIDTH];
    assign operand = ir_q[`SAP_OPERAND_WIDTH-1:0];

    // ==================================================================
    // Internal bus
    // ==================================================================

    // Priority mux in place of a tri-state bus
    // PC and operand are zero-extended to the data width
    always_comb begin
        if (cw.oe_pc) begin
            bus = {{(`SAP_DATA_WIDTH-`SAP_ADDR_WIDTH){1'b0}}, pc_q};
        end else if (cw.oe_ram) begin
            bus = mem_rdata_i;
        end else if (cw.oe_ir) begin
            bus = {{(`SAP_DATA_WIDTH-`SAP_OPERAND_WIDTH){1'b0}}, operand};
        end else if (cw.oe_alu) begin
            bus = alu_result;
        end else if (cw.oe_a) begin
            bus = a_q;
        end else begin
            bus = '0;
        end
    end

    // ==================================================================
    // Registers
    // ==================================================================

    // Jump load wins over increment
    always_ff @(posedge clk) begin
        if (rst_i) begin
            pc_q <= '0;
        end else if (cw.load_pc) begin
            pc_q <= bus[`SAP_ADDR_WIDTH-1:0];
        end else if (cw.pc_enable) begin
            pc_q <= pc_q + arch_defs_pkg::addr_t'(1);
        end
    end

    // A, B, MAR and IR all load from the bus
    always_ff @(posedge clk) begin
        if (rst_i) begin
            a_q   <= '0;
            b_q   <= '0;
            mar_q <= '0;
            ir_q  <= '0;
        end else begin
            if (cw.load_a) begin
                a_q <= bus;
            end
            if (cw.load_b) begin
                b_q <= bus;
            end
            if (cw.load_mar) begin
                mar_q <= bus[`SAP_ADDR_WIDTH-1:0];
            end
            if (cw.load_ir) begin
                ir_q <= bus;
            end
        end
    end

    // ==================================================================
    // Flags
    // ==================================================================

    // Loads take Z and N from the bus value and always clear carry
    always_comb begin
        flags_d = alu_flags;
        if (cw.load_sets_zn) begin
            flags_d.zero     = (bus == '0);
            flags_d.negative = bus[`SAP_DATA_WIDTH-1];
            flags_d.carry    = 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (rst_i) begin
            flags_q <= '0;
        end else if (cw.load_flags) begin
            flags_q <= flags_d;
        end
    end

    assign flags_o = flags_q;

    // Memory bus, store data always comes from A
    assign mem_addr_o  = mar_q;
    assign mem_read_o  = cw.oe_ram;
    assign mem_write_o = cw.load_ram;
    assign mem_wdata_o = a_q;
    assign load_o      = cw.load_o;
    assign halt_o      = cw.halt;

    control_unit u_control_unit (
        .clk            (clk),
        .rst_i          (rst_i),
        .opcode_i       (opcode),
        .flags_i        (flags_o),
        .control_word_o (cw)
    );

    alu u_alu (
        .clk      (clk),
        .rst_i    (rst_i),
        .a_i      (a_q),
        .b_i      (b_q),
        .alu_op_i (cw.alu_op),
        .result_o (alu_result),
        .flags_o  (alu_flags)
    );

endmodule

/* logic/memory_io.sv */
`timescale 1ns/100ps
`include "sap_defs.svh"

module memory_io (
    input  logic                 clk,
    input  logic                 rst_i,
    input  logic                 prog_we_i,
    input  arch_defs_pkg::addr_t prog_addr_i,
    input  arch_defs_pkg::data_t prog_data_i,
    input  arch_defs_pkg::addr_t mem_addr_i,
    input  logic                 mem_read_i,
    input  logic                 mem_write_i,
    input  logic                 load_i,
    input  arch_defs_pkg::data_t mem_wdata_i,
    output arch_defs_pkg::data_t mem_rdata_o,
    output arch_defs_pkg::data_t out_o,
    output logic                 out_valid_o
);

    arch_defs_pkg::data_t ram_q [`SAP_RAM_DEPTH];
    arch_defs_pkg::data_t out_q;
    logic                 out_valid_q;

    // Program port owns the RAM while the CPU is in reset
    always_ff @(posedge clk) begin
        if (rst_i) begin
            if (prog_we_i) begin
                ram_q[prog_addr_i] <= prog_data_i;
            end
        end else if (mem_write_i) begin
            ram_q[mem_addr_i] <= mem_wdata_i;
        end
    end

    // Asynchronous read, bus reads zero when not selected
    assign mem_rdata_o = mem_read_i ? ram_q[mem_addr_i] : '0;

    // Output port, valid pulses once per OUT
    always_ff @(posedge clk) begin
        if (rst_i) begin
            out_q       <= '0;
            out_valid_q <= 1'b0;
        end else begin
            out_valid_q <= load_i;
            if (load_i) begin
                out_q <= mem_wdata_i;
            end
        end
    end

    assign out_o       = out_q;
    assign out_valid_o = out_valid_q;

endmodule

/* logic/sap_top.sv */
`timescale 1ns/100ps

module sap_top (
    input  logic                  clk,
    input  logic                  rst_i,
    input  logic                  prog_we_i,
    input  arch_defs_pkg::addr_t  prog_addr_i,
    input  arch_defs_pkg::data_t  prog_data_i,
    output arch_defs_pkg::data_t  out_o,
    output logic                  out_valid_o,
    output logic                  halt_o,
    output arch_defs_pkg::flags_t flags_o
);

    // ======================= CPU to memory ============================
    arch_defs_pkg::addr_t mem_addr;
    arch_defs_pkg::data_t mem_rdata;
    arch_defs_pkg::data_t mem_wdata;
    logic                 mem_read;
    logic                 mem_write;
    logic                 load_out;

    cpu u_cpu (
        .clk         (clk),
        .rst_i       (rst_i),
        .mem_rdata_i (mem_rdata),
        .mem_addr_o  (mem_addr),
        .mem_read_o  (mem_read),
        .mem_write_o (mem_write),
        .mem_wdata_o (mem_wdata),
        .load_o      (load_out),
        .halt_o      (halt_o),
        .flags_o     (flags_o)
    );

    // RAM plus output port, loaded through the program port during reset
    memory_io u_memory_io (
        .clk         (clk),
        .rst_i       (rst_i),
        .prog_we_i   (prog_we_i),
        .prog_addr_i (prog_addr_i),
        .prog_data_i (prog_data_i),
        .mem_addr_i  (mem_addr),
        .mem_read_i  (mem_read),
        .mem_write_i (mem_write),
        .load_i      (load_out),
        .mem_wdata_i (mem_wdata),
        .mem_rdata_o (mem_rdata),
        .out_o       (out_o),
        .out_valid_o (out_valid_o)
    );

endmodule

/* sap_cpu.f */
+incdir+include
logic/arch_defs_pkg.sv
logic/alu.sv
logic/control_unit.sv
logic/cpu.sv
logic/memory_io.sv
logic/sap_top.sv
tests/sap_chk.sv
tests/sap_tb.sv

/* tests/sap_chk.sv */
`timescale 1ns/100ps

module sap_chk (
    input logic                  clk,
    input logic                  rst_i,
    input logic                  out_valid_i,
    input logic                  halt_i,
    input arch_defs_pkg::data_t  out_i,
    input arch_defs_pkg::flags_t flags_i
);

    // Read by the testbench for its final verdict
    int error_count = 0;

    // ==================================================================
    // Output port
    // ==================================================================

    // Each OUT gives a single-cycle strobe
    out_valid_pulse: assert property (@(posedge clk) disable iff (rst_i)
        out_valid_i |=> !out_valid_i)
        else begin
            $error("out_valid_o stayed high for more than one cycle");
            error_count++;
        end

    // ==================================================================
    // Halt
    // ==================================================================

    // Only reset releases a halted CPU
    halt_sticky: assert property (@(posedge clk) disable iff (rst_i)
        halt_i |=> halt_i)
        else begin
            $error("halt_o dropped without a reset");
            error_count++;
        end

    // Halted CPU is silent
    no_output_halted: assert property (@(posedge clk) disable iff (rst_i)
        halt_i |-> !out_valid_i)
        else begin
            $error("out_valid_o seen while halted");
            error_count++;
        end

    // First cycle out of reset
    reset_clean: assert property (@(posedge clk)
        $fell(rst_i) |-> (!halt_i && !out_valid_i && flags_i == '0 && out_i == '0))
        else begin
            $error("outputs not cleared in the cycle after reset");
            error_count++;
        end

endmodule

bind sap_top sap_chk u_chk (
    .clk         (clk),
    .rst_i       (rst_i),
    .out_valid_i (out_valid_o),
    .halt_i      (halt_o),
    .out_i       (out_o),
    .flags_i     (flags_o)
);

/* tests/sap_tb.sv */
`timescale 1ns/100ps

module sap_tb;

    // ==================================================================
    // Run limits
    // ==================================================================
    localparam int RESET_CYCLES = 10;
    localparam int PROG_WORDS   = 10;
    localparam int HALT_WATCH   = 6;
    localparam int NUM_TESTS    = 17;
    // At most 4 cycles per instruction and doubled for margin
    localparam int TIMEOUT_CYCLES =
        2 * NUM_TESTS * (PROG_WORDS * 4 + RESET_CYCLES + HALT_WATCH);

    // One RAM word to load through the program port
    typedef struct packed {
        arch_defs_pkg::addr_t addr;
        arch_defs_pkg::data_t data;
    } prog_word_t;

    // One expected OUT result
    typedef struct packed {
        arch_defs_pkg::data_t  value;
        arch_defs_pkg::flags_t flags;
    } expect_t;

    logic                  clk;
    logic                  rst_i;
    logic                  prog_we_i;
    arch_defs_pkg::addr_t  prog_addr_i;
    arch_defs_pkg::data_t  prog_data_i;
    arch_defs_pkg::data_t  out_o;
    logic                  out_valid_o;
    logic                  halt_o;
    arch_defs_pkg::flags_t flags_o;

    prog_word_t  prog_q[$];
    expect_t     exp_q[$];
    logic [15:0] lfsr_q;
    int          cycle_count = 0;
    int          fail_count = 0;
    int          tests_run = 0;
    int          tests_failed = 0;

    sap_top UUT (
        .clk         (clk),
        .rst_i       (rst_i),
        .prog_we_i   (prog_we_i),
        .prog_addr_i (prog_addr_i),
        .prog_data_i (prog_data_i),
        .out_o       (out_o),
        .out_valid_o (out_valid_o),
        .halt_o      (halt_o),
        .flags_o     (flags_o)
    );

    // 40 ns period
    always #20 clk = ~clk;

    // Hang guard
    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= TIMEOUT_CYCLES) begin
            $display("Timeout: the CPU never halted within %0d cycles, the run hung", cycle_count);
            $display("TESTBENCH FAILED");
            $finish;
        end
    end

    // ==================================================================
    // Helpers
    // ==================================================================
    function automatic arch_defs_pkg::data_t instr(arch_defs_pkg::opcode_t op, int arg);
        return {op, arch_defs_pkg::operand_t'(arg)};
    endfunction

    // Fibonacci LFSR with taps 16 14 13 11
    function automatic logic [15:0] lfsr_next(logic [15:0] s);
        return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
    endfunction

    // One LFSR step per bit taken
    function automatic arch_defs_pkg::data_t random_bits(int n);
        arch_defs_pkg::data_t v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr_q = lfsr_next(lfsr_q);
            v = {v[6:0], lfsr_q[0]};
        end
        return v;
    endfunction

    // ISA rule for ADD and SUB results where carry on SUB means A >= B
    function automatic expect_t alu_expect(arch_defs_pkg::data_t a, arch_defs_pkg::data_t b,
                                           logic subtract);
        int      r;
        expect_t e;
        r = subtract ? (int'(a) - int'(b) + 256) % 256 : (int'(a) + int'(b)) % 256;
        e.value          = arch_defs_pkg::data_t'(r);
        e.flags.carry    = subtract ? (a >= b) : ((int'(a) + int'(b)) > 255);
        e.flags.zero     = (r == 0);
        e.flags.negative = (r >= 128);
        return e;
    endfunction

    // ISA rule for loads that always clear carry
    function automatic expect_t load_expect(arch_defs_pkg::data_t v);
        expect_t e;
        e.value          = v;
        e.flags.carry    = 1'b0;
        e.flags.zero     = (v == 0);
        e.flags.negative = (v >= 128);
        return e;
    endfunction

    task automatic put(int addr, arch_defs_pkg::data_t data);
        prog_q.push_back({arch_defs_pkg::addr_t'(addr), data});
    endtask

    // Reset for 10 cycles while loading one word per cycle
    task automatic load_program();
        @(posedge clk);
        rst_i <= 1'b1;
        for (int i = 0; i < RESET_CYCLES; i++) begin
            if (i < prog_q.size()) begin
                prog_we_i   <= 1'b1;
                prog_addr_i <= prog_q[i].addr;
                prog_data_i <= prog_q[i].data;
            end else begin
                prog_we_i <= 1'b0;
            end
            @(posedge clk);
        end
        rst_i     <= 1'b0;
        prog_we_i <= 1'b0;
        prog_q.delete();
    endtask

    task automatic check_output(string name);
        expect_t e;
        if (exp_q.size() == 0) begin
            $display("%s: the CPU produced an unexpected output %02h", name, out_o);
            fail_count++;
        end else begin
            e = exp_q.pop_front();
            assert (out_o == e.value) else begin
                $display("[FAIL] %s out_o: expected %02h, actual %02h", name, e.value, out_o);
                fail_count++;
            end
            assert (flags_o == e.flags) else begin
                $display("[FAIL] %s flags: expected %03b, actual %03b", name, e.flags, flags_o);
                fail_count++;
            end
        end
    endtask

    // Load, release reset, collect outputs until HLT, then watch the halt
    task automatic run_test(string name);
        int fails_before;
        fails_before = fail_count;
        tests_run++;
        load_program();
        @(negedge clk);
        assert (!halt_o && !out_valid_o && flags_o == '0) else begin
            $display("[FAIL] %s reset: expected halt 0 valid 0 flags 000, actual %0b %0b %03b",
                     name, halt_o, out_valid_o, flags_o);
            fail_count++;
        end
        while (!halt_o) begin
            if (out_valid_o) begin
                check_output(name);
            end
            @(negedge clk);
        end
        repeat (HALT_WATCH) begin
            @(negedge clk);
            assert (halt_o && !out_valid_o) else begin
                $display("%s: halt_o dropped or an output appeared after HLT", name);
                fail_count++;
            end
        end
        if (exp_q.size() != 0) begin
            $display("%s: %0d expected outputs never appeared", name, exp_q.size());
            fail_count++;
            exp_q.delete();
        end
        if (fail_count == fails_before) begin
            $display("%s: passed", name);
        end else begin
            tests_failed++;
            $display("%s: failed", name);
        end
    endtask

    // ==================================================================
    // Test programs
    // ==================================================================
    task automatic alu_test(string name, arch_defs_pkg::data_t a, arch_defs_pkg::data_t b,
                            logic subtract);
        put(0, instr(arch_defs_pkg::LDA, 14));
        put(1, instr(arch_defs_pkg::LDB, 15));
        put(2, instr(subtract ? arch_defs_pkg::SUB : arch_defs_pkg::ADD, 0));
        put(3, instr(arch_defs_pkg::OUT, 0));
        put(4, instr(arch_defs_pkg::HLT, 0));
        put(14, a);
        put(15, b);
        exp_q.push_back(alu_expect(a, b, subtract));
        run_test(name);
    endtask

    // Operand goes through RAM address 13 while A holds its complement
    task automatic store_load_test(string name, int imm);
        put(0, instr(arch_defs_pkg::LDI, imm));
        put(1, instr(arch_defs_pkg::STA, 13));
        put(2, instr(arch_defs_pkg::LDI, imm ^ 15));
        put(3, instr(arch_defs_pkg::LDA, 13));
        put(4, instr(arch_defs_pkg::OUT, 0));
        put(5, instr(arch_defs_pkg::HLT, 0));
        exp_q.push_back(load_expect(arch_defs_pkg::data_t'(imm)));
        run_test(name);
    endtask

    // ADD with carry out first, then LDI 0 must clear carry and set zero
    task automatic zero_flag_test(string name, arch_defs_pkg::data_t a, arch_defs_pkg::data_t b);
        put(0, instr(arch_defs_pkg::LDA, 14));
        put(1, instr(arch_defs_pkg::LDB, 15));
        put(2, instr(arch_defs_pkg::ADD, 0));
        put(3, instr(arch_defs_pkg::OUT, 0));
        put(4, instr(arch_defs_pkg::LDI, 0));
        put(5, instr(arch_defs_pkg::OUT, 0));
        put(6, instr(arch_defs_pkg::HLT, 0));
        put(14, a);
        put(15, b);
        exp_q.push_back(alu_expect(a, b, 1'b0));
        exp_q.push_back(load_expect(8'h00));
        run_test(name);
    endtask

    // Two setup words, jump at 2, fall-through outputs 1, target at 6 outputs 2
    task automatic jump_test(string name, arch_defs_pkg::data_t setup0,
                             arch_defs_pkg::data_t setup1, arch_defs_pkg::data_t data15,
                             arch_defs_pkg::opcode_t jop, logic taken);
        put(0, setup0);
        put(1, setup1);
        put(2, instr(jop, 6));
        put(3, instr(arch_defs_pkg::LDI, 1));
        put(4, instr(arch_defs_pkg::OUT, 0));
        put(5, instr(arch_defs_pkg::HLT, 0));
        put(6, instr(arch_defs_pkg::LDI, 2));
        put(7, instr(arch_defs_pkg::OUT, 0));
        put(8, instr(arch_defs_pkg::HLT, 0));
        put(15, data15);
        exp_q.push_back(load_expect(taken ? 8'd2 : 8'd1));
        run_test(name);
    endtask

    // ==================================================================
    // Main sequence
    // ==================================================================
    initial begin : main
        arch_defs_pkg::data_t a;
        arch_defs_pkg::data_t b;
        arch_defs_pkg::data_t nop;
        int                   total_fail;
        clk         = 1'b0;
        rst_i       = 1'b1;
        prog_we_i   = 1'b0;
        prog_addr_i = '0;
        prog_data_i = '0;
        lfsr_q      = 16'd50020;
        nop         = instr(arch_defs_pkg::NOP, 0);

        // Reset state with a lone HLT as the program
        put(0, instr(arch_defs_pkg::HLT, 0));
        run_test("reset");

        alu_test("add_random", random_bits(8), random_bits(8), 1'b0);
        alu_test("add_carry", random_bits(8) | 8'h80, random_bits(8) | 8'h80, 1'b0);
        a = random_bits(8);
        alu_test("add_zero", a, 8'(256 - int'(a)), 1'b0);

        a = random_bits(8);
        alu_test("sub_equal", a, a, 1'b1);
        a = random_bits(7);
        b = a + 8'd1 + random_bits(7);
        alu_test("sub_less", a, b, 1'b1);
        alu_test("sub_random", random_bits(8), random_bits(8), 1'b1);

        store_load_test("store_load", int'(random_bits(4)));
        zero_flag_test("ldi_zero_flags", random_bits(8) | 8'h80, random_bits(8) | 8'h80);

        // B is zero after reset, so SUB sets carry and ADD clears it
        jump_test("jmp", nop, nop, 8'h00, arch_defs_pkg::JMP, 1'b1);
        jump_test("jz_taken", instr(arch_defs_pkg::LDI, 0), nop, 8'h00, arch_defs_pkg::JZ, 1'b1);
        jump_test("jz_not_taken", instr(arch_defs_pkg::LDI, 5), nop, 8'h00,
                  arch_defs_pkg::JZ, 1'b0);
        jump_test("jc_taken", instr(arch_defs_pkg::LDI, 3), instr(arch_defs_pkg::SUB, 0), 8'h00,
                  arch_defs_pkg::JC, 1'b1);
        jump_test("jc_not_taken", instr(arch_defs_pkg::LDI, 3), instr(arch_defs_pkg::ADD, 0),
                  8'h00, arch_defs_pkg::JC, 1'b0);
        jump_test("jn_taken", instr(arch_defs_pkg::LDA, 15), nop, random_bits(8) | 8'h80,
                  arch_defs_pkg::JN, 1'b1);
        jump_test("jn_not_taken", instr(arch_defs_pkg::LDA, 15), nop, random_bits(8) & 8'h7f,
                  arch_defs_pkg::JN, 1'b0);

        // OUT after HLT must never run
        put(0, instr(arch_defs_pkg::LDI, 7));
        put(1, instr(arch_defs_pkg::HLT, 0));
        put(2, instr(arch_defs_pkg::OUT, 0));
        put(3, instr(arch_defs_pkg::HLT, 0));
        run_test("halt");

        total_fail = fail_count + UUT.u_chk.error_count;
        $display("Summary: %0d tests, %0d passed, %0d failed, %0d check errors, %0d assert errors",
                 tests_run, tests_run - tests_failed, tests_failed, fail_count,
                 UUT.u_chk.error_count);
        if (total_fail == 0) begin
            $display("TESTBENCH PASSED");
        end else begin
            $display("TESTBENCH FAILED");
        end
        $finish;
    end

endmodule
